/* flist.f */
logic/fetch_pkg.sv
logic/fetch_icache.sv
logic/fetch_miss_unit.sv
logic/fetch_insn_fifo.sv
logic/fetch_unit.sv
logic/fetch_top.sv
dv/fetch_sva.sv
dv/fetch_tb.sv

/* dv/fetch_tb.sv */
//****************************************
// Random testbench for fetch_top at the
// default parameters. Memory holds a fixed
// pattern; redirects stay in 512 bytes
//****************************************
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int LINE_WORDS  = 4;
    localparam int IC_LINES    = 16;
    localparam int LINE_BYTES  = LINE_WORDS * 4;
    localparam int LINE_W      = LINE_WORDS * INSN_WIDTH;
    localparam int N_INSNS     = 3000;
    localparam int WATCHDOG_NS = N_INSNS * 12 * CLK_PERIOD;

    logic                  clk;
    logic                  i_arst_n;
    logic                  i_redirect;
    logic [ADDR_WIDTH-1:0] i_redirect_addr;
    logic                  i_decode_stall;
    logic                  o_fetch_valid;
    logic [ADDR_WIDTH-1:0] o_fetch_pc;
    logic [INSN_WIDTH-1:0] o_fetch_insn;
    logic                  o_mem_req;
    logic [ADDR_WIDTH-1:0] o_mem_addr;
    logic                  i_mem_ack;
    logic [LINE_W-1:0]     i_mem_data;

    logic [31:0]           lcg_state;
    logic [ADDR_WIDTH-1:0] exp_pc;
    int                    checked;
    logic                  mem_busy;
    int                    mem_wait;
    // Lines the cache holds, by index
    logic [IC_LINES-1:0]   res_valid;
    logic [ADDR_WIDTH-1:0] res_line [IC_LINES];

    fetch_top i_dut (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_decode_stall  (i_decode_stall),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_insn    (o_fetch_insn),
        .o_mem_req       (o_mem_req),
        .o_mem_addr      (o_mem_addr),
        .i_mem_ack       (i_mem_ack),
        .i_mem_data      (i_mem_data)
    );

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // Memory content at byte address addr
    function automatic logic [INSN_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] addr);
        return addr * 32'h9E37_79B1 + 32'h1234_5678;
    endfunction

    function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_WIDTH-1:0] line_addr);
        logic [LINE_W-1:0] line;
        line = '0;
        for (int w = 0; w < LINE_WORDS; w++) begin
            line[w*INSN_WIDTH +: INSN_WIDTH] = mem_word(line_addr + 4 * w);
        end
        return line;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // Stall and redirect still hold the values of the previous cycle here
    task automatic check_outputs();
        assert (!(i_redirect && o_fetch_valid))
        else fail_run($sformatf("mismatch o_fetch_valid after redirect: got %h expected %h",
                                o_fetch_valid, 1'b0));
        assert (!(i_decode_stall && o_fetch_valid))
        else fail_run($sformatf("mismatch o_fetch_valid after stall: got %h expected %h",
                                o_fetch_valid, 1'b0));
        if (o_fetch_valid) begin
            assert (o_fetch_pc == exp_pc)
            else fail_run($sformatf("mismatch o_fetch_pc: got %h expected %h",
                                    o_fetch_pc, exp_pc));
            assert (o_fetch_insn == mem_word(o_fetch_pc))
            else fail_run($sformatf("mismatch o_fetch_insn: got %h expected %h",
                                    o_fetch_insn, mem_word(o_fetch_pc)));
            exp_pc  = exp_pc + 4;
            checked = checked + 1;
        end
        assert (i_dut.u_sva.error_count == 0)
        else fail_run("a bound protocol assertion on fetch_top failed");
    endtask

    task automatic respond_memory();
        logic [ADDR_WIDTH-1:0] line_num;
        int                    idx;
        line_num = o_mem_addr / LINE_BYTES;
        idx      = line_num % IC_LINES;
        if (i_mem_ack) begin
            // Release phase
            if (!o_mem_req) begin
                i_mem_ack  = 1'b0;
                i_mem_data = '0;
                mem_busy   = 1'b0;
            end
        end else if (mem_busy) begin
            assert (o_mem_req) else fail_run("memory request dropped before it was acknowledged");
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                i_mem_ack  = 1'b1;
                i_mem_data = line_data(o_mem_addr);
            end
        end else if (o_mem_req) begin
            assert (o_mem_addr % LINE_BYTES == 0)
            else fail_run($sformatf("memory request address %h is not line aligned", o_mem_addr));
            assert (!(res_valid[idx] && res_line[idx] == line_num))
            else fail_run($sformatf("memory request for line %h that the cache still holds",
                                    o_mem_addr));
            res_valid[idx] = 1'b1;
            res_line[idx]  = line_num;
            mem_busy       = 1'b1;
            mem_wait       = next_rand() % 6 + 1;
        end
    endtask

    task automatic drive_frontend();
        i_decode_stall = (next_rand() % 100) < 30;
        i_redirect     = (next_rand() % 40) == 0;
        if (i_redirect) begin
            i_redirect_addr = (next_rand() % 128) * 4;
            exp_pc          = i_redirect_addr;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run($sformatf("timeout, fetch outputs stopped after %0d of %0d instructions",
                           checked, N_INSNS));
    end

    initial begin
        i_arst_n        = 1'b0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_decode_stall  = 1'b0;
        i_mem_ack       = 1'b0;
        i_mem_data      = '0;
        lcg_state       = 32'd18477;
        exp_pc          = '0;
        checked         = 0;
        mem_busy        = 1'b0;
        mem_wait        = 0;
        res_valid       = '0;
        repeat (4) @(negedge clk);
        i_arst_n = 1'b1;
        while (checked < N_INSNS) begin
            @(negedge clk);
            check_outputs();
            respond_memory();
            drive_frontend();
        end
        if (i_dut.u_sva.error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("a bound protocol assertion on fetch_top failed");
            $display("TEST RESULT: FAIL");
            $fatal(1, "protocol assertion errors");
        end
    end

endmodule

/* dv/fetch_sva.sv */
//****************************************
// Memory handshake and redirect output
// rules for fetch_top
// Inactive while i_arst_n is low
//****************************************
`timescale 1ns/10ps

module fetch_sva (
    input logic                             clk,
    input logic                             i_arst_n,
    input logic                             i_mem_req,
    input logic [fetch_pkg::ADDR_WIDTH-1:0] i_mem_addr,
    input logic                             i_mem_ack,
    input logic                             i_redirect,
    input logic                             i_fetch_valid
);
    int error_count = 0;

    // Request holds until memory answers
    req_held: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_mem_req && !i_mem_ack |=> i_mem_req)
    else begin
        $error("o_mem_req dropped before i_mem_ack rose");
        error_count = error_count + 1;
    end

    addr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_mem_req && $past(i_mem_req) |-> $stable(i_mem_addr))
    else begin
        $error("o_mem_addr changed while o_mem_req was high");
        error_count = error_count + 1;
    end

    // A new request waits for ack to fall
    no_req_under_ack: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_mem_ack |-> !$rose(i_mem_req))
    else begin
        $error("o_mem_req rose while i_mem_ack was still high");
        error_count = error_count + 1;
    end

    redirect_bubble: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_redirect |=> !i_fetch_valid)
    else begin
        $error("o_fetch_valid high in the cycle after i_redirect");
        error_count = error_count + 1;
    end

endmodule

bind fetch_top fetch_sva u_sva (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_mem_req     (o_mem_req),
    .i_mem_addr    (o_mem_addr),
    .i_mem_ack     (i_mem_ack),
    .i_redirect    (i_redirect),
    .i_fetch_valid (o_fetch_valid)
);

/* logic/fetch_top.sv */
//****************************************
// Instruction fetch front end
// i_mem_data carries a whole cache line
// One miss outstanding at a time
//****************************************
`timescale 1ns/10ps

module fetch_top #(
    parameter int P_LINE_WORDS = 4,
    parameter int P_IC_LINES   = 16,
    parameter int P_FIFO_DEPTH = 8
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_redirect,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]              i_redirect_addr,
    input  logic                                          i_decode_stall,
    output logic                                          o_fetch_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]              o_fetch_pc,
    output logic [fetch_pkg::INSN_WIDTH-1:0]              o_fetch_insn,
    output logic                                          o_mem_req,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]              o_mem_addr,
    input  logic                                          i_mem_ack,
    input  logic [P_LINE_WORDS*fetch_pkg::INSN_WIDTH-1:0] i_mem_data
);
    import fetch_pkg::*;

    localparam int LINE_W = P_LINE_WORDS * INSN_WIDTH;

    logic                  lookup_en;
    logic                  hit;
    logic                  miss_valid;
    logic                  miss_ready;
    logic                  fill_valid;
    logic                  push;
    logic                  full;
    logic                  pop;
    logic                  flush;
    logic                  empty;
    logic [ADDR_WIDTH-1:0] lookup_addr;
    logic [ADDR_WIDTH-1:0] miss_addr;
    logic [ADDR_WIDTH-1:0] fill_addr;
    logic [ADDR_WIDTH-1:0] push_pc;
    logic [ADDR_WIDTH-1:0] head_pc;
    logic [INSN_WIDTH-1:0] hit_insn;
    logic [INSN_WIDTH-1:0] push_insn;
    logic [INSN_WIDTH-1:0] head_insn;
    logic [LINE_W-1:0]     fill_line;

    fetch_icache #(
        .P_LINE_WORDS (P_LINE_WORDS),
        .P_IC_LINES   (P_IC_LINES)
    ) u_icache (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_lookup_en   (lookup_en),
        .i_lookup_addr (lookup_addr),
        .i_fill_valid  (fill_valid),
        .i_fill_addr   (fill_addr),
        .i_fill_line   (fill_line),
        .o_hit         (hit),
        .o_hit_insn    (hit_insn)
    );

    // Fill goes to the cache and the fetch unit together
    fetch_miss_unit #(
        .P_LINE_WORDS (P_LINE_WORDS)
    ) u_miss_unit (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_miss_valid (miss_valid),
        .i_miss_addr  (miss_addr),
        .o_miss_ready (miss_ready),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_ack    (i_mem_ack),
        .i_mem_data   (i_mem_data),
        .o_fill_valid (fill_valid),
        .o_fill_addr  (fill_addr),
        .o_fill_line  (fill_line)
    );

    fetch_unit #(
        .P_LINE_WORDS (P_LINE_WORDS)
    ) u_fetch_unit (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_decode_stall  (i_decode_stall),
        .o_lookup_en     (lookup_en),
        .o_lookup_addr   (lookup_addr),
        .i_hit           (hit),
        .i_hit_insn      (hit_insn),
        .o_miss_valid    (miss_valid),
        .o_miss_addr     (miss_addr),
        .i_miss_ready    (miss_ready),
        .i_fill_valid    (fill_valid),
        .i_fill_addr     (fill_addr),
        .o_push          (push),
        .o_push_pc       (push_pc),
        .o_push_insn     (push_insn),
        .i_full          (full),
        .o_pop           (pop),
        .o_flush         (flush),
        .i_head_pc       (head_pc),
        .i_head_insn     (head_insn),
        .i_empty         (empty),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_insn    (o_fetch_insn)
    );

    fetch_insn_fifo #(
        .P_FIFO_DEPTH (P_FIFO_DEPTH)
    ) u_insn_fifo (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (flush),
        .i_push      (push),
        .i_push_pc   (push_pc),
        .i_push_insn (push_insn),
        .o_full      (full),
        .i_pop       (pop),
        .o_head_pc   (head_pc),
        .o_head_insn (head_insn),
        .o_empty     (empty)
    );

endmodule

/* logic/fetch_unit.sv */
//****************************************
// Fetch control: PC, lookup pipeline,
// miss requests and FIFO push/pop
// No branch prediction; redirect wins
//****************************************
`timescale 1ns/10ps

module fetch_unit #(
    parameter int P_LINE_WORDS = 4
) (
    input  logic                             clk,
    input  logic                             i_arst_n,
    input  logic                             i_redirect,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] i_redirect_addr,
    input  logic                             i_decode_stall,
    // Cache lookup
    output logic                             o_lookup_en,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] o_lookup_addr,
    input  logic                             i_hit,
    input  logic [fetch_pkg::INSN_WIDTH-1:0] i_hit_insn,
    // Miss unit
    output logic                             o_miss_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] o_miss_addr,
    input  logic                             i_miss_ready,
    input  logic                             i_fill_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] i_fill_addr,
    // Instruction FIFO
    output logic                             o_push,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] o_push_pc,
    output logic [fetch_pkg::INSN_WIDTH-1:0] o_push_insn,
    input  logic                             i_full,
    output logic                             o_pop,
    output logic                             o_flush,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] i_head_pc,
    input  logic [fetch_pkg::INSN_WIDTH-1:0] i_head_insn,
    input  logic                             i_empty,
    // Decoder
    output logic                             o_fetch_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] o_fetch_pc,
    output logic [fetch_pkg::INSN_WIDTH-1:0] o_fetch_insn
);
    import fetch_pkg::*;

    localparam int LINE_OFF = $clog2(P_LINE_WORDS) + 2;

    fetch_state_e          state_q;
    fetch_state_e          state_d;
    logic [ADDR_WIDTH-1:0] pc_q;
    logic [ADDR_WIDTH-1:0] pc_d;
    logic                  s1_valid_q;
    logic [ADDR_WIDTH-1:0] s1_pc_q;
    logic [ADDR_WIDTH-1:0] restart_pc_q;
    logic                  fill_q;
    logic                  s1_hit;
    logic                  s1_miss;
    logic                  stop;
    logic                  retry;
    logic                  fill_match;

    // Stage 1 holds the PC whose lookup result is visible now
    assign s1_hit  = s1_valid_q && i_hit;
    assign s1_miss = s1_valid_q && !i_hit;
    assign stop    = s1_miss || (s1_hit && i_full);

    // A line filled during or just after the lookup is simply looked up again
    assign retry = s1_miss && (i_fill_valid || fill_q);

    assign fill_match = i_fill_valid &&
        (i_fill_addr[ADDR_WIDTH-1:LINE_OFF] == restart_pc_q[ADDR_WIDTH-1:LINE_OFF]);

    // Younger PC is dropped by not issuing it
    assign o_lookup_en   = (state_q == FETCH_RUN) && !i_redirect && !stop;
    assign o_lookup_addr = pc_q;

    assign o_push      = s1_hit && !i_full && !i_redirect;
    assign o_push_pc   = s1_pc_q;
    assign o_push_insn = i_hit_insn;

    assign o_miss_valid = (state_q == FETCH_MISS_REQ) && !i_redirect;
    assign o_miss_addr  = restart_pc_q;

    assign o_pop   = !i_empty && !i_decode_stall && !i_redirect;
    assign o_flush = i_redirect;

    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        case (state_q)
            FETCH_RUN: begin
                if (retry) begin
                    pc_d = s1_pc_q;
                end else if (s1_miss) begin
                    state_d = FETCH_MISS_REQ;
                end else if (s1_hit && i_full) begin
                    state_d = FETCH_FIFO_WAIT;
                end else begin
                    pc_d = pc_q + 4;
                end
            end
            FETCH_MISS_REQ: begin
                // An earlier miss may already have brought this line in
                if (fill_match) begin
                    state_d = FETCH_RUN;
                    pc_d    = restart_pc_q;
                end else if (i_miss_ready) begin
                    state_d = FETCH_MISS_WAIT;
                end
            end
            FETCH_MISS_WAIT: begin
                if (fill_match) begin
                    state_d = FETCH_RUN;
                    pc_d    = restart_pc_q;
                end
            end
            FETCH_FIFO_WAIT: begin
                if (!i_full) begin
                    state_d = FETCH_RUN;
                    pc_d    = restart_pc_q;
                end
            end
            default: state_d = FETCH_RUN;
        endcase
        if (i_redirect) begin
            state_d = FETCH_RUN;
            pc_d    = i_redirect_addr;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q       <= FETCH_RUN;
            pc_q          <= '0;
            s1_valid_q    <= 1'b0;
            fill_q        <= 1'b0;
            o_fetch_valid <= 1'b0;
        end else begin
            state_q       <= state_d;
            pc_q          <= pc_d;
            s1_valid_q    <= o_lookup_en;
            fill_q        <= i_fill_valid;
            o_fetch_valid <= o_pop;
        end
    end

    always_ff @(posedge clk) begin
        s1_pc_q <= pc_q;
        // Restart from the first PC that was not pushed
        if (state_q == FETCH_RUN && stop) begin
            restart_pc_q <= s1_pc_q;
        end
        if (o_pop) begin
            o_fetch_pc   <= i_head_pc;
            o_fetch_insn <= i_head_insn;
        end
    end

endmodule

/* logic/fetch_insn_fifo.sv */
//****************************************
// FIFO of (pc, instruction) pairs
// Depth must be a power of two >= 2
// Caller must not push when full
//****************************************
`timescale 1ns/10ps

module fetch_insn_fifo #(
    parameter int P_FIFO_DEPTH = 8
) (
    input  logic                             clk,
    input  logic                             i_arst_n,
    input  logic                             i_flush,
    input  logic                             i_push,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0] i_push_pc,
    input  logic [fetch_pkg::INSN_WIDTH-1:0] i_push_insn,
    output logic                             o_full,
    input  logic                             i_pop,
    output logic [fetch_pkg::ADDR_WIDTH-1:0] o_head_pc,
    output logic [fetch_pkg::INSN_WIDTH-1:0] o_head_insn,
    output logic                             o_empty
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(P_FIFO_DEPTH);

    logic [ADDR_WIDTH-1:0] pc_mem   [P_FIFO_DEPTH];
    logic [INSN_WIDTH-1:0] insn_mem [P_FIFO_DEPTH];
    logic [PTR_W:0]        wr_ptr_q;
    logic [PTR_W:0]        rd_ptr_q;

    // Extra pointer bit tells full from empty
    assign o_empty = (wr_ptr_q == rd_ptr_q);
    assign o_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                     (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

    assign o_head_pc   = pc_mem[rd_ptr_q[PTR_W-1:0]];
    assign o_head_insn = insn_mem[rd_ptr_q[PTR_W-1:0]];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (i_flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (i_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (i_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_push && !i_flush) begin
            pc_mem[wr_ptr_q[PTR_W-1:0]]   <= i_push_pc;
            insn_mem[wr_ptr_q[PTR_W-1:0]] <= i_push_insn;
        end
    end

endmodule

/* logic/fetch_miss_unit.sv */
//****************************************
// Single outstanding miss to memory over
// a four-phase req/ack handshake
// Fill pulses only after ack has dropped
//****************************************
`timescale 1ns/10ps

module fetch_miss_unit #(
    parameter int P_LINE_WORDS = 4
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_miss_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]              i_miss_addr,
    output logic                                          o_miss_ready,
    output logic                                          o_mem_req,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]              o_mem_addr,
    input  logic                                          i_mem_ack,
    input  logic [P_LINE_WORDS*fetch_pkg::INSN_WIDTH-1:0] i_mem_data,
    output logic                                          o_fill_valid,
    output logic [fetch_pkg::ADDR_WIDTH-1:0]              o_fill_addr,
    output logic [P_LINE_WORDS*fetch_pkg::INSN_WIDTH-1:0] o_fill_line
);
    import fetch_pkg::*;

    localparam int LINE_OFF = $clog2(P_LINE_WORDS) + 2;

    miss_state_e                        state_q;
    miss_state_e                        state_d;
    logic [ADDR_WIDTH-1:0]              addr_q;
    logic [P_LINE_WORDS*INSN_WIDTH-1:0] line_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            MISS_IDLE:    if (i_miss_valid) state_d = MISS_REQ;
            MISS_REQ:     if (i_mem_ack) state_d = MISS_RELEASE;
            MISS_RELEASE: if (!i_mem_ack) state_d = MISS_FILL;
            MISS_FILL:    state_d = MISS_IDLE;
            default:      state_d = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= MISS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Line-aligned request address and captured line
    always_ff @(posedge clk) begin
        if (state_q == MISS_IDLE && i_miss_valid) begin
            addr_q <= {i_miss_addr[ADDR_WIDTH-1:LINE_OFF], {LINE_OFF{1'b0}}};
        end
        if (state_q == MISS_REQ && i_mem_ack) begin
            line_q <= i_mem_data;
        end
    end

    assign o_miss_ready = (state_q == MISS_IDLE);
    assign o_mem_req    = (state_q == MISS_REQ);
    assign o_mem_addr   = addr_q;
    assign o_fill_valid = (state_q == MISS_FILL);
    assign o_fill_addr  = addr_q;
    assign o_fill_line  = line_q;

endmodule

/* logic/fetch_icache.sv */
//****************************************
// Direct-mapped instruction cache
// Lookup result is registered one cycle
// Both parameters must be powers of two >= 2
//****************************************
`timescale 1ns/10ps

module fetch_icache #(
    parameter int P_LINE_WORDS = 4,
    parameter int P_IC_LINES   = 16
) (
    input  logic                                          clk,
    input  logic                                          i_arst_n,
    input  logic                                          i_lookup_en,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]              i_lookup_addr,
    input  logic                                          i_fill_valid,
    input  logic [fetch_pkg::ADDR_WIDTH-1:0]              i_fill_addr,
    input  logic [P_LINE_WORDS*fetch_pkg::INSN_WIDTH-1:0] i_fill_line,
    output logic                                          o_hit,
    output logic [fetch_pkg::INSN_WIDTH-1:0]              o_hit_insn
);
    import fetch_pkg::*;

    localparam int OFF_W   = $clog2(P_LINE_WORDS);
    localparam int IDX_W   = $clog2(P_IC_LINES);
    localparam int TAG_LSB = 2 + OFF_W + IDX_W;
    localparam int TAG_W   = ADDR_WIDTH - TAG_LSB;

    logic [P_IC_LINES-1:0]                   valid_q;
    logic [TAG_W-1:0]                        tag_q  [P_IC_LINES];
    logic [P_LINE_WORDS-1:0][INSN_WIDTH-1:0] data_q [P_IC_LINES];

    logic [OFF_W-1:0] lk_off;
    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] fill_tag;
    logic             lk_hit;

    // Address split into tag, line index and word offset
    assign lk_off   = i_lookup_addr[2 +: OFF_W];
    assign lk_idx   = i_lookup_addr[2+OFF_W +: IDX_W];
    assign lk_tag   = i_lookup_addr[TAG_LSB +: TAG_W];
    assign fill_idx = i_fill_addr[2+OFF_W +: IDX_W];
    assign fill_tag = i_fill_addr[TAG_LSB +: TAG_W];

    // Arrays are read before a same-cycle fill lands
    assign lk_hit = i_lookup_en && valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            o_hit   <= 1'b0;
        end else begin
            o_hit <= lk_hit;
            if (i_fill_valid) begin
                valid_q[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        o_hit_insn <= data_q[lk_idx][lk_off];
        if (i_fill_valid) begin
            tag_q[fill_idx]  <= fill_tag;
            data_q[fill_idx] <= i_fill_line;
        end
    end

endmodule

/* logic/fetch_pkg.sv */
//****************************************
// Widths and FSM encodings shared by the
// fetch front end. Addresses are byte
// addresses and instructions are 4 bytes
//****************************************
package fetch_pkg;

    // Instruction word and byte address widths
    localparam int INSN_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // Fetch control FSM
    typedef enum logic [1:0] {
        FETCH_RUN       = 2'b00,
        FETCH_MISS_REQ  = 2'b01,
        FETCH_MISS_WAIT = 2'b10,
        FETCH_FIFO_WAIT = 2'b11
    } fetch_state_e;

    // Miss unit FSM for the four-phase memory handshake
    typedef enum logic [1:0] {
        MISS_IDLE    = 2'b00,
        MISS_REQ     = 2'b01, // req held until ack rises
        MISS_RELEASE = 2'b10, // req low until ack falls
        MISS_FILL    = 2'b11
    } miss_state_e;

endpackage
